// File: Makefile
TOP := tb_gmii_to_rgmii

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim.f
source/rgmii_pkg.sv
source/bit_count_if.sv
source/mdio_bit_counter.sv
source/mdio_frame_fsm.sv
source/rgmii_tx_encoder.sv
source/rgmii_rx_decoder.sv
source/gmii_to_rgmii.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_gmii_to_rgmii.sv

// File: source/bit_count_if.sv
`timescale 1ns/1ps

// link between the MDIO frame state machine and its field bit counter
interface bit_count_if;

  // restart the count at zero
  logic       clear;
  // one MDC rising edge seen
  logic       step;
  // length of the current field minus one
  logic [4:0] field_len;
  // count has reached field_len
  logic       last;

  modport fsm (output clear, output step, output field_len, input last);

  modport counter (input clear, input step, input field_len, output last);

endinterface

// File: source/gmii_to_rgmii.sv
`timescale 1ns/1ps

module gmii_to_rgmii #(
  parameter logic [4:0] phy_addr = 5'd16
) (
  input  logic       gmii_tx_clk_s,
  input  logic       reset,
  input  logic       mdio_mdc,
  input  logic       mdio_in_w,
  input  logic       mdio_in_r,
  input  logic [7:0] gmii_txd,
  input  logic       gmii_tx_en,
  input  logic       gmii_tx_er,
  output logic [3:0] txd_rise,
  output logic [3:0] txd_fall,
  output logic       tx_ctl_rise,
  output logic       tx_ctl_fall,
  input  logic [3:0] rxd_rise,
  input  logic [3:0] rxd_fall,
  input  logic       rx_ctl_rise,
  input  logic       rx_ctl_fall,
  output logic [7:0] gmii_rxd,
  output logic       gmii_rx_dv,
  output logic       gmii_rx_er,
  output logic       gmii_crs,
  output logic       gmii_col,
  output logic [1:0] link_speed,
  output logic       full_duplex
);

  // stage one transmit flags for carrier sense
  logic tx_en_q;
  logic tx_er_q;

  // ********************************************************
  // management bus monitor
  // ********************************************************

  bit_count_if cnt_bus ();

  mdio_bit_counter u_bit_counter (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .cnt           (cnt_bus.counter)
  );

  mdio_frame_fsm #(
    .phy_addr (phy_addr)
  ) u_frame_fsm (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .mdio_mdc      (mdio_mdc),
    .mdio_in_w     (mdio_in_w),
    .mdio_in_r     (mdio_in_r),
    .cnt           (cnt_bus.fsm),
    .link_speed    (link_speed),
    .full_duplex   (full_duplex)
  );

  // ********************************************************
  // data paths
  // ********************************************************

  rgmii_tx_encoder u_tx_encoder (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .gmii_txd      (gmii_txd),
    .gmii_tx_en    (gmii_tx_en),
    .gmii_tx_er    (gmii_tx_er),
    .link_speed    (link_speed),
    .tx_en_q       (tx_en_q),
    .tx_er_q       (tx_er_q),
    .txd_rise      (txd_rise),
    .txd_fall      (txd_fall),
    .tx_ctl_rise   (tx_ctl_rise),
    .tx_ctl_fall   (tx_ctl_fall)
  );

  rgmii_rx_decoder u_rx_decoder (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .rxd_rise      (rxd_rise),
    .rxd_fall      (rxd_fall),
    .rx_ctl_rise   (rx_ctl_rise),
    .rx_ctl_fall   (rx_ctl_fall),
    .tx_en_q       (tx_en_q),
    .tx_er_q       (tx_er_q),
    .full_duplex   (full_duplex),
    .gmii_rxd      (gmii_rxd),
    .gmii_rx_dv    (gmii_rx_dv),
    .gmii_rx_er    (gmii_rx_er),
    .gmii_crs      (gmii_crs),
    .gmii_col      (gmii_col)
  );

endmodule

// File: source/mdio_bit_counter.sv
`timescale 1ns/1ps

module mdio_bit_counter (
  input  logic         gmii_tx_clk_s,
  input  logic         reset,
  bit_count_if.counter cnt
);

  // position of the current bit inside the field
  logic [4:0] count;

  // clear wins over step so a field change starts the new field at zero
  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      count <= 5'd0;
    end else if (cnt.clear) begin
      count <= 5'd0;
    end else if (cnt.step) begin
      count <= count + 5'd1;
    end
  end

  assign cnt.last = (count == cnt.field_len);

  // the state machine must clear the count when the last bit of a field
  // arrives, so a plain step always finds the count below field_len
  no_overrun: assert property (
    @(posedge gmii_tx_clk_s) disable iff (reset)
      (cnt.step && !cnt.clear) |-> (count < cnt.field_len)
  );

  // field_len only changes together with a clear
  len_stable: assert property (
    @(posedge gmii_tx_clk_s) disable iff (reset)
      !$past(cnt.clear) && !$past(reset) |-> $stable(cnt.field_len)
  );

endmodule

// File: source/mdio_frame_fsm.sv
`timescale 1ns/1ps

module mdio_frame_fsm
  import rgmii_pkg::*;
#(
  parameter logic [4:0] phy_addr = 5'd16
) (
  input  logic       gmii_tx_clk_s,
  input  logic       reset,
  input  logic       mdio_mdc,
  input  logic       mdio_in_w,
  input  logic       mdio_in_r,
  bit_count_if.fsm   cnt,
  output logic [1:0] link_speed,
  output logic       full_duplex
);

  mdio_state_t         state;
  mdio_state_t         state_next;
  mdio_op_t            op_q;
  logic                mdc_q;
  logic                mdc_rise;
  logic [4:0]          phy_q;
  logic [4:0]          reg_q;
  logic [data_len-2:0] data_q;
  logic [data_len-1:0] data_word;
  logic                frame_hit;

  // last bit index of the field that a state walks through
  function automatic logic [4:0] field_last(input mdio_state_t st);
    int len;
    case (st)
      st_preamble:   len = preamble_len;
      st_start:      len = start_len;
      st_opcode:     len = opcode_len;
      st_phy_addr:   len = phy_addr_len;
      st_reg_addr:   len = reg_addr_len;
      st_turnaround: len = turnaround_len;
      st_data:       len = data_len;
      default:       len = 1;
    endcase
    return 5'(len - 1);
  endfunction

  // ********************************************************
  // MDC edge detection
  // ********************************************************

  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      mdc_q <= 1'b0;
    end else begin
      mdc_q <= mdio_mdc;
    end
  end

  assign mdc_rise      = mdio_mdc & ~mdc_q;
  assign cnt.step      = mdc_rise;
  assign cnt.field_len = field_last(state);

  // ********************************************************
  // frame walk
  // ********************************************************

  always_comb begin
    state_next = state;
    cnt.clear  = 1'b0;
    case (state)
      st_idle: begin
        state_next = st_preamble;
        cnt.clear  = 1'b1;
      end
      st_preamble: begin
        // any zero means the ones seen so far were not a preamble
        if (mdc_rise && !mdio_in_w) begin
          cnt.clear = 1'b1;
        end else if (mdc_rise && cnt.last) begin
          state_next = st_start;
          cnt.clear  = 1'b1;
        end
      end
      st_start: begin
        // start is 01 so the expected bit equals last
        if (mdc_rise && (mdio_in_w != cnt.last)) begin
          state_next = st_preamble;
          cnt.clear  = 1'b1;
        end else if (mdc_rise && cnt.last) begin
          state_next = st_opcode;
          cnt.clear  = 1'b1;
        end
      end
      st_data: begin
        if (mdc_rise && cnt.last) begin
          state_next = st_idle;
          cnt.clear  = 1'b1;
        end
      end
      default: begin
        // header fields follow each other in enum order
        if (mdc_rise && cnt.last) begin
          state_next = mdio_state_t'(state + 3'd1);
          cnt.clear  = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // header bits come from the station side and data from the PHY side
  always_ff @(posedge gmii_tx_clk_s) begin
    if (mdc_rise) begin
      case (state)
        st_opcode:   op_q   <= mdio_op_t'({op_q[0], mdio_in_w});
        st_phy_addr: phy_q  <= {phy_q[3:0], mdio_in_w};
        st_reg_addr: reg_q  <= {reg_q[3:0], mdio_in_w};
        st_data:     data_q <= {data_q[data_len-3:0], mdio_in_r};
        default: ;
      endcase
    end
  end

  // ********************************************************
  // link state capture
  // ********************************************************

  assign data_word = {data_q, mdio_in_r};
  assign frame_hit = (op_q == op_read) && (phy_q == phy_addr) &&
                     (reg_q == status_reg_addr);

  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      link_speed  <= 2'b00;
      full_duplex <= 1'b0;
    end else if ((state == st_data) && mdc_rise && cnt.last && frame_hit) begin
      link_speed  <= data_word[status_speed_msb -: 2];
      full_duplex <= data_word[status_duplex_bit];
    end
  end

  // all eight codes are states, so only an unknown value is illegal
  state_legal: assert property (
    @(posedge gmii_tx_clk_s) disable iff (reset) !$isunknown(state)
  );

endmodule

// File: source/rgmii_pkg.sv
package rgmii_pkg;

  // states of the passive MDIO frame monitor, listed in frame order
  typedef enum logic [2:0] {
    st_idle,
    st_preamble,
    st_start,
    st_opcode,
    st_phy_addr,
    st_reg_addr,
    st_turnaround,
    st_data
  } mdio_state_t;

  // clause 22 opcodes as they appear on the wire
  typedef enum logic [1:0] {
    op_none  = 2'b00,
    op_write = 2'b01,
    op_read  = 2'b10,
    op_other = 2'b11
  } mdio_op_t;

  // field lengths in MDC periods
  localparam int preamble_len   = 32;
  localparam int start_len      = 2;
  localparam int opcode_len     = 2;
  localparam int phy_addr_len   = 5;
  localparam int reg_addr_len   = 5;
  localparam int turnaround_len = 2;
  localparam int data_len       = 16;

  // PHY specific status register holding the resolved link
  localparam logic [4:0] status_reg_addr   = 5'd17;
  localparam int         status_speed_msb  = 15;
  localparam int         status_duplex_bit = 13;

endpackage

// File: source/rgmii_rx_decoder.sv
`timescale 1ns/1ps

module rgmii_rx_decoder (
  input  logic       gmii_tx_clk_s,
  input  logic       reset,
  input  logic [3:0] rxd_rise,
  input  logic [3:0] rxd_fall,
  input  logic       rx_ctl_rise,
  input  logic       rx_ctl_fall,
  input  logic       tx_en_q,
  input  logic       tx_er_q,
  input  logic       full_duplex,
  output logic [7:0] gmii_rxd,
  output logic       gmii_rx_dv,
  output logic       gmii_rx_er,
  output logic       gmii_crs,
  output logic       gmii_col
);

  logic tx_busy;
  logic rx_busy;

  assign tx_busy = tx_en_q | tx_er_q;
  assign rx_busy = gmii_rx_dv | gmii_rx_er;

  // the falling edge carries the upper nibble and dv xor er
  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      gmii_rxd   <= 8'h00;
      gmii_rx_dv <= 1'b0;
      gmii_rx_er <= 1'b0;
    end else begin
      gmii_rxd   <= {rxd_fall, rxd_rise};
      gmii_rx_dv <= rx_ctl_rise;
      gmii_rx_er <= rx_ctl_rise ^ rx_ctl_fall;
    end
  end

  // carrier sense and collision only exist in half duplex
  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      gmii_crs <= 1'b0;
      gmii_col <= 1'b0;
    end else begin
      gmii_crs <= !full_duplex && (tx_busy || rx_busy);
      gmii_col <= !full_duplex && tx_busy && rx_busy;
    end
  end

  col_needs_crs: assert property (
    @(posedge gmii_tx_clk_s) disable iff (reset) $rose(gmii_col) |-> gmii_crs
  );

endmodule

// File: source/rgmii_tx_encoder.sv
`timescale 1ns/1ps

module rgmii_tx_encoder (
  input  logic       gmii_tx_clk_s,
  input  logic       reset,
  input  logic [7:0] gmii_txd,
  input  logic       gmii_tx_en,
  input  logic       gmii_tx_er,
  input  logic [1:0] link_speed,
  output logic       tx_en_q,
  output logic       tx_er_q,
  output logic [3:0] txd_rise,
  output logic [3:0] txd_fall,
  output logic       tx_ctl_rise,
  output logic       tx_ctl_fall
);

  logic [7:0] txd_q;
  logic       gigabit;

  // speed code 1x selects gigabit
  assign gigabit = link_speed[1];

  // stage one holds the GMII byte and flags
  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      txd_q   <= 8'h00;
      tx_en_q <= 1'b0;
      tx_er_q <= 1'b0;
    end else begin
      txd_q   <= gmii_txd;
      tx_en_q <= gmii_tx_en;
      tx_er_q <= gmii_tx_er;
    end
  end

  // stage two forms the nibble pairs for the DDR output cells
  // at 10 and 100 Mbps the low nibble goes out on both edges
  always_ff @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      txd_rise    <= 4'h0;
      txd_fall    <= 4'h0;
      tx_ctl_rise <= 1'b0;
      tx_ctl_fall <= 1'b0;
    end else begin
      txd_rise    <= txd_q[3:0];
      txd_fall    <= gigabit ? txd_q[7:4] : txd_q[3:0];
      tx_ctl_rise <= tx_en_q;
      tx_ctl_fall <= tx_en_q ^ tx_er_q;
    end
  end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic       gmii_tx_clk_s,
  input  logic       reset,
  input  logic [7:0] gmii_txd,
  input  logic       gmii_tx_en,
  input  logic       gmii_tx_er,
  input  logic [3:0] rxd_rise,
  input  logic [3:0] rxd_fall,
  input  logic       rx_ctl_rise,
  input  logic       rx_ctl_fall,
  input  logic [1:0] exp_speed,
  input  logic       exp_duplex,
  input  logic [3:0] txd_rise,
  input  logic [3:0] txd_fall,
  input  logic       tx_ctl_rise,
  input  logic       tx_ctl_fall,
  input  logic [7:0] gmii_rxd,
  input  logic       gmii_rx_dv,
  input  logic       gmii_rx_er,
  input  logic       gmii_crs,
  input  logic       gmii_col,
  input  logic [1:0] link_speed,
  input  logic       full_duplex,
  input  logic       report,
  output int         error_count
);

  int         errors = 0;
  int         checks = 0;
  logic       armed = 1'b0;
  logic [7:0] tx1_d;
  logic       tx1_en;
  logic       tx1_er;
  logic [3:0] model_rise;
  logic [3:0] model_fall;
  logic       model_ctl_rise;
  logic       model_ctl_fall;
  logic [7:0] model_rxd;
  logic       model_dv;
  logic       model_er;
  logic       model_crs;
  logic       model_col;
  logic [1:0] model_speed;
  logic       model_duplex;

  assign error_count = errors;

  initial begin
    $timeformat(-9, 0, " ns", 0);
  end

  task automatic compare(input string name, input logic [7:0] actual,
                         input logic [7:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // ************************************************************
  // reference model, advanced on every rising edge
  // ************************************************************

  always @(posedge gmii_tx_clk_s) begin
    if (reset) begin
      armed          <= 1'b1;
      tx1_d          <= 8'h00;
      tx1_en         <= 1'b0;
      tx1_er         <= 1'b0;
      model_rise     <= 4'h0;
      model_fall     <= 4'h0;
      model_ctl_rise <= 1'b0;
      model_ctl_fall <= 1'b0;
      model_rxd      <= 8'h00;
      model_dv       <= 1'b0;
      model_er       <= 1'b0;
      model_crs      <= 1'b0;
      model_col      <= 1'b0;
      model_speed    <= 2'b00;
      model_duplex   <= 1'b0;
    end else begin
      tx1_d          <= gmii_txd;
      tx1_en         <= gmii_tx_en;
      tx1_er         <= gmii_tx_er;
      model_rise     <= tx1_d[3:0];
      // only gigabit puts the upper nibble on the falling edge
      model_fall     <= model_speed[1] ? tx1_d[7:4] : tx1_d[3:0];
      model_ctl_rise <= tx1_en;
      model_ctl_fall <= tx1_en ^ tx1_er;
      model_rxd      <= {rxd_fall, rxd_rise};
      model_dv       <= rx_ctl_rise;
      model_er       <= rx_ctl_rise ^ rx_ctl_fall;
      model_crs      <= !model_duplex && (tx1_en || tx1_er || model_dv || model_er);
      model_col      <= !model_duplex && (tx1_en || tx1_er) && (model_dv || model_er);
      model_speed    <= exp_speed;
      model_duplex   <= exp_duplex;
    end
  end

  // outputs are compared half a cycle after they settle
  always @(negedge gmii_tx_clk_s) begin
    if (armed) begin
      compare("txd_rise", 8'(txd_rise), 8'(model_rise));
      compare("txd_fall", 8'(txd_fall), 8'(model_fall));
      compare("tx_ctl_rise", 8'(tx_ctl_rise), 8'(model_ctl_rise));
      compare("tx_ctl_fall", 8'(tx_ctl_fall), 8'(model_ctl_fall));
      compare("gmii_rxd", gmii_rxd, model_rxd);
      compare("gmii_rx_dv", 8'(gmii_rx_dv), 8'(model_dv));
      compare("gmii_rx_er", 8'(gmii_rx_er), 8'(model_er));
      compare("gmii_crs", 8'(gmii_crs), 8'(model_crs));
      compare("gmii_col", 8'(gmii_col), 8'(model_col));
      compare("link_speed", 8'(link_speed), 8'(model_speed));
      compare("full_duplex", 8'(full_duplex), 8'(model_duplex));
    end
  end

  always @(posedge report) begin
    $display("checker closing: %0d checks, %0d errors", checks, errors);
  end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int reset_cycles = 16
) (
  output logic gmii_tx_clk_s,
  output logic reset
);

  // 10 ns period
  initial begin
    gmii_tx_clk_s = 1'b0;
    forever #5 gmii_tx_clk_s = ~gmii_tx_clk_s;
  end

  // reset is released on a falling edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge gmii_tx_clk_s);
    @(negedge gmii_tx_clk_s);
    reset = 1'b0;
  end

endmodule

// File: testbench/tb_gmii_to_rgmii.sv
`timescale 1ns/1ps

module tb_gmii_to_rgmii;

  localparam logic [4:0] dut_phy_addr  = 5'd21;
  localparam logic [4:0] status_reg    = 5'd17;
  localparam int         num_frames    = 11;
  localparam int         mdc_period    = 8;
  localparam int         data_cycles   = 400;
  localparam int         margin_cycles = 1000;
  localparam int         timeout_ns    =
    (num_frames * 64 * mdc_period + data_cycles + 16 + margin_cycles) * 10;

  logic        gmii_tx_clk_s;
  logic        reset;
  logic        mdio_mdc;
  logic        mdio_in_w;
  logic        mdio_in_r;
  logic [7:0]  gmii_txd;
  logic        gmii_tx_en;
  logic        gmii_tx_er;
  logic [3:0]  txd_rise;
  logic [3:0]  txd_fall;
  logic        tx_ctl_rise;
  logic        tx_ctl_fall;
  logic [3:0]  rxd_rise;
  logic [3:0]  rxd_fall;
  logic        rx_ctl_rise;
  logic        rx_ctl_fall;
  logic [7:0]  gmii_rxd;
  logic        gmii_rx_dv;
  logic        gmii_rx_er;
  logic        gmii_crs;
  logic        gmii_col;
  logic [1:0]  link_speed;
  logic        full_duplex;
  logic [1:0]  exp_speed;
  logic        exp_duplex;
  logic        report;
  logic        mdio_done;
  int          error_count;
  logic [31:0] lfsr = 32'd32;
  logic [1:0]  frame_op [num_frames];
  logic [4:0]  frame_phy [num_frames];
  logic [4:0]  frame_reg [num_frames];
  logic        frame_bad [num_frames];
  logic [15:0] frame_data [num_frames];

  tb_clock_gen u_clock_gen (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset)
  );

  gmii_to_rgmii #(
    .phy_addr (dut_phy_addr)
  ) i_gmii_to_rgmii (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .mdio_mdc      (mdio_mdc),
    .mdio_in_w     (mdio_in_w),
    .mdio_in_r     (mdio_in_r),
    .gmii_txd      (gmii_txd),
    .gmii_tx_en    (gmii_tx_en),
    .gmii_tx_er    (gmii_tx_er),
    .txd_rise      (txd_rise),
    .txd_fall      (txd_fall),
    .tx_ctl_rise   (tx_ctl_rise),
    .tx_ctl_fall   (tx_ctl_fall),
    .rxd_rise      (rxd_rise),
    .rxd_fall      (rxd_fall),
    .rx_ctl_rise   (rx_ctl_rise),
    .rx_ctl_fall   (rx_ctl_fall),
    .gmii_rxd      (gmii_rxd),
    .gmii_rx_dv    (gmii_rx_dv),
    .gmii_rx_er    (gmii_rx_er),
    .gmii_crs      (gmii_crs),
    .gmii_col      (gmii_col),
    .link_speed    (link_speed),
    .full_duplex   (full_duplex)
  );

  tb_checker u_checker (
    .gmii_tx_clk_s (gmii_tx_clk_s),
    .reset         (reset),
    .gmii_txd      (gmii_txd),
    .gmii_tx_en    (gmii_tx_en),
    .gmii_tx_er    (gmii_tx_er),
    .rxd_rise      (rxd_rise),
    .rxd_fall      (rxd_fall),
    .rx_ctl_rise   (rx_ctl_rise),
    .rx_ctl_fall   (rx_ctl_fall),
    .exp_speed     (exp_speed),
    .exp_duplex    (exp_duplex),
    .txd_rise      (txd_rise),
    .txd_fall      (txd_fall),
    .tx_ctl_rise   (tx_ctl_rise),
    .tx_ctl_fall   (tx_ctl_fall),
    .gmii_rxd      (gmii_rxd),
    .gmii_rx_dv    (gmii_rx_dv),
    .gmii_rx_er    (gmii_rx_er),
    .gmii_crs      (gmii_crs),
    .gmii_col      (gmii_col),
    .link_speed    (link_speed),
    .full_duplex   (full_duplex),
    .report        (report),
    .error_count   (error_count)
  );

  // ************************************************************
  // random numbers
  // ************************************************************

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic get_bits(input int n, output logic [31:0] value);
    value = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic add_frame(input int idx, input logic [1:0] op, input logic [4:0] phy,
                           input logic [4:0] regad, input logic bad, input logic fix_link,
                           input logic [2:0] link);
    logic [31:0] bits;
    get_bits(16, bits);
    frame_op[idx]   = op;
    frame_phy[idx]  = phy;
    frame_reg[idx]  = regad;
    frame_bad[idx]  = bad;
    frame_data[idx] = bits[15:0];
    if (fix_link) begin
      frame_data[idx][15:13] = link;
    end
  endtask

  // ************************************************************
  // MDIO bit-banging, 4 clocks low and 4 clocks high per bit
  // ************************************************************

  task automatic mdio_bit(input logic w, input logic r, input logic update,
                          input logic [2:0] link);
    @(negedge gmii_tx_clk_s);
    mdio_mdc  = 1'b0;
    mdio_in_w = w;
    mdio_in_r = r;
    repeat (4) @(negedge gmii_tx_clk_s);
    mdio_mdc = 1'b1;
    // the monitor loads the link on the edge that samples this rise
    if (update) begin
      exp_speed  = link[2:1];
      exp_duplex = link[0];
    end
    repeat (3) @(negedge gmii_tx_clk_s);
  endtask

  task automatic send_frame(input int idx);
    logic [15:0] data;
    logic        hit;
    logic        is_write;
    data     = frame_data[idx];
    is_write = (frame_op[idx] == 2'b01);
    hit      = (frame_op[idx] == 2'b10) && (frame_phy[idx] == dut_phy_addr) &&
               (frame_reg[idx] == status_reg) && !frame_bad[idx];
    for (int i = 0; i < 32; i++) begin
      mdio_bit(1'b1, 1'b1, 1'b0, 3'b000);
    end
    // a broken start sends 11 instead of 01
    mdio_bit(frame_bad[idx], 1'b1, 1'b0, 3'b000);
    mdio_bit(1'b1, 1'b1, 1'b0, 3'b000);
    for (int i = 1; i >= 0; i--) begin
      mdio_bit(frame_op[idx][i], 1'b1, 1'b0, 3'b000);
    end
    for (int i = 4; i >= 0; i--) begin
      mdio_bit(frame_phy[idx][i], 1'b1, 1'b0, 3'b000);
    end
    for (int i = 4; i >= 0; i--) begin
      mdio_bit(frame_reg[idx][i], 1'b1, 1'b0, 3'b000);
    end
    mdio_bit(1'b1, 1'b1, 1'b0, 3'b000);
    mdio_bit(1'b0, 1'b0, 1'b0, 3'b000);
    for (int i = 15; i >= 0; i--) begin
      mdio_bit(is_write ? data[i] : 1'b1, data[i], hit && (i == 0), data[15:13]);
    end
    // one zero restarts the preamble count whatever state the frame left
    mdio_bit(1'b0, 1'b0, 1'b0, 3'b000);
  endtask

  task automatic drive_traffic();
    logic [31:0] bits;
    @(negedge gmii_tx_clk_s);
    get_bits(21, bits);
    gmii_txd    = bits[7:0];
    gmii_tx_en  = bits[8];
    gmii_tx_er  = bits[9] & bits[10];
    rxd_rise    = bits[14:11];
    rxd_fall    = bits[18:15];
    rx_ctl_rise = bits[19];
    rx_ctl_fall = bits[20];
  endtask

  initial begin
    mdio_mdc    = 1'b0;
    mdio_in_w   = 1'b1;
    mdio_in_r   = 1'b1;
    gmii_txd    = 8'h00;
    gmii_tx_en  = 1'b0;
    gmii_tx_er  = 1'b0;
    rxd_rise    = 4'h0;
    rxd_fall    = 4'h0;
    rx_ctl_rise = 1'b0;
    rx_ctl_fall = 1'b0;
    exp_speed   = 2'b00;
    exp_duplex  = 1'b0;
    report      = 1'b0;
    mdio_done   = 1'b0;
    // link codes are speed and duplex, status bits 15:13
    // frames that must be ignored carry a link code unlike the current one
    add_frame(0, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b101);
    add_frame(1, 2'b10, dut_phy_addr ^ 5'd4, status_reg, 1'b0, 1'b1, 3'b010);
    add_frame(2, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b100);
    add_frame(3, 2'b10, dut_phy_addr, 5'd1, 1'b0, 1'b1, 3'b011);
    add_frame(4, 2'b01, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b001);
    add_frame(5, 2'b10, dut_phy_addr, status_reg, 1'b1, 1'b1, 3'b011);
    add_frame(6, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b010);
    add_frame(7, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b001);
    add_frame(8, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b000);
    add_frame(9, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b0, 3'b000);
    add_frame(10, 2'b10, dut_phy_addr, status_reg, 1'b0, 1'b1, 3'b110);
    @(negedge reset);
    // a quiet stretch shows the reset values
    repeat (4) @(negedge gmii_tx_clk_s);
    fork
      begin
        for (int i = 0; i < num_frames; i++) begin
          send_frame(i);
        end
        mdio_done = 1'b1;
      end
      begin
        while (!mdio_done) begin
          drive_traffic();
        end
      end
    join
    repeat (data_cycles) begin
      drive_traffic();
    end
    repeat (4) @(negedge gmii_tx_clk_s);
    @(posedge gmii_tx_clk_s);
    report = 1'b1;
    #1;
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired after %0d ns with the tests still running", timeout_ns);
    $display("Finished with errors");
    $finish;
  end

endmodule
